/* cu_pkg.sv */
package cu_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int OPCODE_BITS      = 4;
    localparam int OFFMEM_ADDR_BITS = 32;
    localparam int INST_BITS        = OPCODE_BITS + 2 * OFFMEM_ADDR_BITS;
    localparam int DATA_BITS        = 128;
    localparam int UB_ADDR_BITS     = 8;
    localparam int ACC_ADDR_BITS    = 6;
    // Byte offset within one 128-bit line
    localparam int ADDR_LSB         = 4;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam logic [OPCODE_BITS-1:0] OP_IDLE            = 4'h0;
    localparam logic [OPCODE_BITS-1:0] OP_DATA_FIFO       = 4'h1;
    localparam logic [OPCODE_BITS-1:0] OP_AXI_TO_UB       = 4'h3;
    localparam logic [OPCODE_BITS-1:0] OP_UB_TO_DATA_FIFO = 4'h5;
    localparam logic [OPCODE_BITS-1:0] OP_MAT_MUL         = 4'h7;
    localparam logic [OPCODE_BITS-1:0] OP_MAT_MUL_ACC     = 4'h8;
    localparam logic [OPCODE_BITS-1:0] OP_ACC_TO_UB       = 4'h9;
    localparam logic [OPCODE_BITS-1:0] OP_UB_TO_AXI       = 4'ha;

    // AXI state machine modes
    localparam logic [1:0] AXI_IDLE  = 2'd0;
    localparam logic [1:0] AXI_LOAD  = 2'd1;
    localparam logic [1:0] AXI_STORE = 2'd2;

    ////////////////////
    // Address word
    ////////////////////
    // Same 32 bits seen as a byte address or as a buffer line
    typedef union packed {
        logic [OFFMEM_ADDR_BITS-1:0] full;
        struct packed {
            logic [OFFMEM_ADDR_BITS-UB_ADDR_BITS-ADDR_LSB-1:0] upper;
            logic [UB_ADDR_BITS-1:0]                            line_idx;
            logic [ADDR_LSB-1:0]                                byte_off;
        } line_view;
    } offmem_addr_u;

endpackage

/* cu_step_if.sv */
`timescale 1ns/1ps

interface cu_step_if import cu_pkg::*; ();

    // Sequencer state
    logic [OPCODE_BITS-1:0] opcode;
    logic [1:0]             step;
    logic                   active;
    offmem_addr_u           addra;
    offmem_addr_u           addrb;

    // Step reports from the decoders
    logic local_advance;
    logic local_last;
    logic xfer_advance;
    logic xfer_done;

    modport seq (
        output opcode, step, active, addra, addrb,
        input  local_advance, local_last, xfer_advance, xfer_done
    );

    modport strobe (
        input  opcode, step, active, addra, addrb,
        output local_advance, local_last
    );

    modport xfer (
        input  opcode, step, active, addra, addrb,
        output xfer_advance, xfer_done
    );

endinterface

/* inst_sequencer.sv */
`timescale 1ns/1ps

module inst_sequencer import cu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [INST_BITS-1:0] instruction,
    input  logic                 init_inst_pulse,
    output logic                 flag,
    output logic                 idle_flag,
    cu_step_if.seq               step_if
);

    logic                   pulse_d;
    logic                   inst_pulse;
    logic                   op_idle;
    logic [OPCODE_BITS-1:0] opcode_q;
    logic [1:0]             step_q;
    offmem_addr_u           addra_q;
    offmem_addr_u           addrb_q;

    // Rising edge of the instruction strobe
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pulse_d <= 1'b0;
        end else begin
            pulse_d <= init_inst_pulse;
        end
    end

    assign inst_pulse = init_inst_pulse & ~pulse_d;

    always_ff @(posedge clk) begin
        if (inst_pulse) begin
            addra_q.full <= instruction[2*OFFMEM_ADDR_BITS-1 -: OFFMEM_ADDR_BITS];
            addrb_q.full <= instruction[OFFMEM_ADDR_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            opcode_q <= OP_IDLE;
            step_q   <= 2'd0;
            flag     <= 1'b0;
        end else if (inst_pulse) begin
            opcode_q <= instruction[INST_BITS-1 -: OPCODE_BITS];
            step_q   <= 2'd0;
            flag     <= 1'b0;
        end else if (!flag) begin
            if (step_if.active && (step_if.local_advance || step_if.xfer_advance)) begin
                step_q <= step_q + 2'd1;
            end
            // Idle completes on its own
            if (op_idle || step_if.local_last || step_if.xfer_done) begin
                flag <= 1'b1;
            end
        end
    end

    assign op_idle   = (opcode_q == OP_IDLE);
    assign idle_flag = op_idle | flag;

    assign step_if.opcode = opcode_q;
    assign step_if.step   = step_q;
    assign step_if.active = ~op_idle & ~flag;
    assign step_if.addra  = addra_q;
    assign step_if.addrb  = addrb_q;

endmodule

/* buffer_strobe_decoder.sv */
`timescale 1ns/1ps

module buffer_strobe_decoder import cu_pkg::*; (
    cu_step_if.strobe                step_if,
    input  logic                     txn_done,
    output logic                     read_ub,
    output logic                     write_ub,
    output logic                     read_acc,
    output logic                     write_acc,
    output logic                     data_fifo_en,
    output logic                     mm_en,
    output logic                     acc_en,
    output logic [UB_ADDR_BITS-1:0]  ub_addra,
    output logic [UB_ADDR_BITS-1:0]  ub_addrb,
    output logic [ACC_ADDR_BITS-1:0] acc_addra,
    output logic [ACC_ADDR_BITS-1:0] acc_addrb
);

    logic [UB_ADDR_BITS-1:0] line_a;
    logic [UB_ADDR_BITS-1:0] line_b;
    logic                    first;

    assign line_a = step_if.addra.line_view.line_idx;
    assign line_b = step_if.addrb.line_view.line_idx;
    assign first  = (step_if.step == 2'd0);

    always_comb begin
        read_ub               = 1'b0;
        write_ub              = 1'b0;
        read_acc              = 1'b0;
        write_acc             = 1'b0;
        data_fifo_en          = 1'b0;
        mm_en                 = 1'b0;
        acc_en                = 1'b0;
        ub_addra              = '0;
        ub_addrb              = '0;
        acc_addra             = '0;
        acc_addrb             = '0;
        step_if.local_advance = 1'b0;
        step_if.local_last    = 1'b0;
        if (step_if.active) begin
            case (step_if.opcode)
                OP_DATA_FIFO: begin
                    data_fifo_en       = 1'b1;
                    step_if.local_last = 1'b1;
                end
                OP_UB_TO_DATA_FIFO: begin
                    read_ub            = 1'b1;
                    data_fifo_en       = 1'b1;
                    ub_addrb           = line_b;
                    step_if.local_last = 1'b1;
                end
                OP_MAT_MUL, OP_MAT_MUL_ACC: begin
                    // Multiply with accumulate also holds acc_en in both steps
                    acc_en = (step_if.opcode == OP_MAT_MUL_ACC);
                    if (first) begin
                        read_ub               = 1'b1;
                        ub_addrb              = line_b;
                        step_if.local_advance = 1'b1;
                    end else begin
                        write_acc          = 1'b1;
                        data_fifo_en       = 1'b1;
                        mm_en              = 1'b1;
                        acc_addra          = line_a[ACC_ADDR_BITS-1:0];
                        step_if.local_last = 1'b1;
                    end
                end
                OP_ACC_TO_UB: begin
                    if (first) begin
                        read_acc              = 1'b1;
                        acc_addrb             = line_b[ACC_ADDR_BITS-1:0];
                        step_if.local_advance = 1'b1;
                    end else begin
                        write_ub           = 1'b1;
                        ub_addra           = line_a;
                        step_if.local_last = 1'b1;
                    end
                end
                OP_AXI_TO_UB: begin
                    // Load data lands in the UB when the transfer ends
                    write_ub = txn_done;
                    ub_addra = line_a;
                end
                OP_UB_TO_AXI: begin
                    read_ub  = first;
                    ub_addrb = first ? line_b : '0;
                end
                default: begin
                    // Unknown opcode runs as a one-cycle no-op
                    step_if.local_last = 1'b1;
                end
            endcase
        end
    end

endmodule

/* xfer_data_control.sv */
`timescale 1ns/1ps

module xfer_data_control import cu_pkg::*; (
    cu_step_if.xfer                     step_if,
    input  logic                        txn_done,
    input  logic [DATA_BITS-1:0]        din,
    input  logic [DATA_BITS-1:0]        uin,
    input  logic [DATA_BITS-1:0]        rin,
    output logic [1:0]                  axi_sm_mode,
    output logic                        init_txn_pulse,
    output logic [OFFMEM_ADDR_BITS-1:0] offmem_addra,
    output logic [OFFMEM_ADDR_BITS-1:0] offmem_addrb,
    output logic [DATA_BITS-1:0]        dout
);

    logic first;

    assign first = (step_if.step == 2'd0);

    always_comb begin
        axi_sm_mode          = AXI_IDLE;
        init_txn_pulse       = 1'b0;
        offmem_addra         = '0;
        offmem_addrb         = '0;
        dout                 = '0;
        step_if.xfer_advance = 1'b0;
        step_if.xfer_done    = 1'b0;
        if (step_if.active) begin
            case (step_if.opcode)
                OP_AXI_TO_UB: begin
                    offmem_addrb = step_if.addrb.full;
                    if (txn_done) begin
                        dout              = din;
                        step_if.xfer_done = 1'b1;
                    end else begin
                        // Start pulse only in the first step, then wait
                        axi_sm_mode          = AXI_LOAD;
                        init_txn_pulse       = first;
                        step_if.xfer_advance = first;
                    end
                end
                OP_UB_TO_AXI: begin
                    if (first) begin
                        step_if.xfer_advance = 1'b1;
                    end else if (txn_done) begin
                        step_if.xfer_done = 1'b1;
                    end else begin
                        axi_sm_mode    = AXI_STORE;
                        init_txn_pulse = 1'b1;
                        offmem_addra   = step_if.addra.full;
                        dout           = uin;
                    end
                end
                OP_ACC_TO_UB: begin
                    // Result word goes to the UB in the second step
                    if (!first) begin
                        dout = rin;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* systolic_cu.sv */
`timescale 1ns/1ps

module systolic_cu import cu_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [INST_BITS-1:0]        instruction,
    input  logic                        init_inst_pulse,
    input  logic                        txn_done,
    input  logic [DATA_BITS-1:0]        din,
    input  logic [DATA_BITS-1:0]        uin,
    input  logic [DATA_BITS-1:0]        rin,
    output logic                        flag,
    output logic                        idle_flag,
    output logic [1:0]                  axi_sm_mode,
    output logic                        init_txn_pulse,
    output logic                        read_ub,
    output logic                        write_ub,
    output logic                        read_acc,
    output logic                        write_acc,
    output logic                        data_fifo_en,
    output logic                        mm_en,
    output logic                        acc_en,
    output logic [UB_ADDR_BITS-1:0]     ub_addra,
    output logic [UB_ADDR_BITS-1:0]     ub_addrb,
    output logic [ACC_ADDR_BITS-1:0]    acc_addra,
    output logic [ACC_ADDR_BITS-1:0]    acc_addrb,
    output logic [OFFMEM_ADDR_BITS-1:0] offmem_addra,
    output logic [OFFMEM_ADDR_BITS-1:0] offmem_addrb,
    output logic [DATA_BITS-1:0]        dout
);

    cu_step_if step_if ();

    inst_sequencer u_seq (
        .clk             (clk),
        .reset_n         (reset_n),
        .instruction     (instruction),
        .init_inst_pulse (init_inst_pulse),
        .flag            (flag),
        .idle_flag       (idle_flag),
        .step_if         (step_if.seq)
    );

    ////////////////////
    // Decoders
    ////////////////////
    buffer_strobe_decoder u_strobe (
        .step_if      (step_if.strobe),
        .txn_done     (txn_done),
        .read_ub      (read_ub),
        .write_ub     (write_ub),
        .read_acc     (read_acc),
        .write_acc    (write_acc),
        .data_fifo_en (data_fifo_en),
        .mm_en        (mm_en),
        .acc_en       (acc_en),
        .ub_addra     (ub_addra),
        .ub_addrb     (ub_addrb),
        .acc_addra    (acc_addra),
        .acc_addrb    (acc_addrb)
    );

    xfer_data_control u_xfer (
        .step_if        (step_if.xfer),
        .txn_done       (txn_done),
        .din            (din),
        .uin            (uin),
        .rin            (rin),
        .axi_sm_mode    (axi_sm_mode),
        .init_txn_pulse (init_txn_pulse),
        .offmem_addra   (offmem_addra),
        .offmem_addrb   (offmem_addrb),
        .dout           (dout)
    );

endmodule

/* systolic_cu_tb.sv */
`timescale 1ns/1ps

module systolic_cu_tb import cu_pkg::*; ();

    localparam int FIELDS    = 11;
    localparam int MAX_TESTS = 24;

    logic                        clk = 1'b0;
    logic                        reset_n;
    logic [INST_BITS-1:0]        instruction;
    logic                        init_inst_pulse;
    logic                        txn_done;
    logic [DATA_BITS-1:0]        din;
    logic [DATA_BITS-1:0]        uin;
    logic [DATA_BITS-1:0]        rin;
    logic                        flag;
    logic                        idle_flag;
    logic [1:0]                  axi_sm_mode;
    logic                        init_txn_pulse;
    logic                        read_ub;
    logic                        write_ub;
    logic                        read_acc;
    logic                        write_acc;
    logic                        data_fifo_en;
    logic                        mm_en;
    logic                        acc_en;
    logic [UB_ADDR_BITS-1:0]     ub_addra;
    logic [UB_ADDR_BITS-1:0]     ub_addrb;
    logic [ACC_ADDR_BITS-1:0]    acc_addra;
    logic [ACC_ADDR_BITS-1:0]    acc_addrb;
    logic [OFFMEM_ADDR_BITS-1:0] offmem_addra;
    logic [OFFMEM_ADDR_BITS-1:0] offmem_addrb;
    logic [DATA_BITS-1:0]        dout;

    logic [31:0] stim [0:FIELDS*MAX_TESTS-1];
    int          timeout_cycles = 0;

    systolic_cu uut (.*);

    always #10 clk = ~clk;

    ////////////////////
    // Checking
    ////////////////////
    task automatic expect_equal(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        assert (act === exp) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Control word holds the dout source, the offmem enables, flag, idle_flag and the strobes
    task automatic check_phase(input string name, input logic [15:0] ctl,
                               input logic [27:0] addrs, input logic [31:0] a,
                               input logic [31:0] b);
        logic [127:0] exp_dout;
        logic [11:0]  strobes;
        case (ctl[15:14])
            2'd1: exp_dout = din;
            2'd2: exp_dout = uin;
            2'd3: exp_dout = rin;
            default: exp_dout = '0;
        endcase
        strobes = {flag, idle_flag, axi_sm_mode, init_txn_pulse, read_ub, write_ub,
                   read_acc, write_acc, data_fifo_en, mm_en, acc_en};
        expect_equal({name, " strobes"}, 128'(ctl[11:0]), 128'(strobes));
        expect_equal({name, " buffer addresses"}, 128'(addrs),
                     128'({ub_addra, ub_addrb, acc_addra, acc_addrb}));
        expect_equal({name, " offmem_addra"}, 128'(ctl[13] ? a : 32'h0), 128'(offmem_addra));
        expect_equal({name, " offmem_addrb"}, 128'(ctl[12] ? b : 32'h0), 128'(offmem_addrb));
        expect_equal({name, " dout"}, exp_dout, dout);
    endtask

    function automatic logic [127:0] random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    ////////////////////
    // One instruction
    ////////////////////
    task automatic run_instruction(input int n);
        int                          base;
        int                          mode;
        int                          waits;
        logic [OPCODE_BITS-1:0]      op;
        logic [OFFMEM_ADDR_BITS-1:0] a;
        logic [OFFMEM_ADDR_BITS-1:0] b;
        base = n * FIELDS;
        op   = stim[base][OPCODE_BITS-1:0];
        mode = stim[base+1];
        a    = stim[base+3];
        b    = stim[base+4];
        if (mode == 0) begin
            waits = 0;
        end else if (mode == 1) begin
            waits = 1;
        end else begin
            waits = stim[base+2];
        end
        @(posedge clk);
        instruction     <= {op, a, b};
        init_inst_pulse <= 1'b1;
        din             <= random_word();
        uin             <= random_word();
        rin             <= random_word();
        // Accepting edge
        @(posedge clk);
        init_inst_pulse <= 1'b0;
        @(negedge clk);
        check_phase($sformatf("test %0d step 0", n), stim[base+5][15:0],
                    stim[base+6][27:0], a, b);
        for (int i = 0; i < waits; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_phase($sformatf("test %0d step 1 cycle %0d", n, i), stim[base+7][15:0],
                        stim[base+8][27:0], a, b);
        end
        if (mode == 2) begin
            @(posedge clk);
            txn_done <= 1'b1;
            @(negedge clk);
            check_phase($sformatf("test %0d txn_done", n), stim[base+9][15:0],
                        stim[base+10][27:0], a, b);
        end
        // Aborted load is left running for the next instruction
        if (mode != 3) begin
            @(posedge clk);
            txn_done <= 1'b0;
            @(negedge clk);
            check_phase($sformatf("test %0d complete", n), 16'h0c00, 28'h0, a, b);
        end
    endtask

    initial begin
        int n;
        int limit;
        reset_n         = 1'b0;
        instruction     = '0;
        init_inst_pulse = 1'b0;
        txn_done        = 1'b0;
        din             = '0;
        uin             = '0;
        rin             = '0;
        void'($urandom(67));
        $readmemh("cu_stimulus.mem", stim);
        limit = 60;
        for (int i = 0; i < MAX_TESTS && stim[i*FIELDS+1] != 32'hf; i++) begin
            limit += stim[i*FIELDS+2] + 6;
        end
        timeout_cycles = limit;

        repeat (10) @(negedge clk);
        check_phase("reset", 16'h0400, 28'h0, 32'h0, 32'h0);
        @(posedge clk);
        reset_n <= 1'b1;

        n = 0;
        while (n < MAX_TESTS && stim[n*FIELDS+1] != 32'hf) begin
            run_instruction(n);
            n++;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired before all instructions completed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

/* cu_stimulus.mem */
// opcode mode(0 one step, 1 two steps, 2 AXI, 3 AXI aborted, f end) txn_delay addra addrb
// then control word and buffer address word for step 0, step 1 and the txn_done cycle
0 0 00 00000000 00000000 0400 0000000 0000 0000000 0000 0000000
1 0 00 00001230 00000450 0004 0000000 0000 0000000 0000 0000000
5 0 00 00001230 00000a70 0044 00a7000 0000 0000000 0000 0000000
2 0 00 00000010 00000020 0000 0000000 0000 0000000 0000 0000000
7 1 00 00000350 00000c80 0040 00c8000 000e 0000d40 0000 0000000
8 1 00 00000ff0 00000120 0041 0012000 000f 0000fc0 0000 0000000
9 1 00 12345670 000002b0 0010 000002b c020 6700000 0000 0000000
3 2 03 00000450 80001000 1180 4500000 1100 4500000 5020 4500000
3 2 01 0000ab00 00002040 1180 b000000 1100 b000000 5020 b000000
a 2 02 40000800 00000330 0040 0033000 a280 0000000 0000 0000000
a 2 05 00c0ffe0 00000ee0 0040 00ee000 a280 0000000 0000 0000000
3 3 02 00000a00 00003000 1180 a000000 1100 a000000 0000 0000000
1 0 00 00000000 00000000 0004 0000000 0000 0000000 0000 0000000
3 2 04 fffffff0 01234560 1180 ff00000 1100 ff00000 5020 ff00000
f 0 00 00000000 00000000 0000 0000000 0000 0000000 0000 0000000
0 f 00 00000000 00000000 0000 0000000 0000 0000000 0000 0000000

/* systolic_cu.f */
cu_pkg.sv
cu_step_if.sv
inst_sequencer.sv
buffer_strobe_decoder.sv
xfer_data_control.sv
systolic_cu.sv
systolic_cu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the systolic_cu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f systolic_cu.f --top-module systolic_cu_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsystolic_cu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
